// ==== design/fpm_params.svh ====
/*
	depths and credit counts of the FPM exponent unit
	FPM_OUT_DEPTH must be at least 1 or decode never issues
*/
`ifndef FPM_PARAMS_SVH
`define FPM_PARAMS_SVH

// input queue entries, also the producer's initial credits
`define FPM_IN_DEPTH 4

// result queue entries, also decode's initial internal credits
`define FPM_OUT_DEPTH 4

// consumer buffer slots
`define FPM_OUT_CREDITS 2

// mantissa width in bits
`define FPM_ALIGN_LIMIT 40

// legal exponent range
`define FPM_EXP_MAX 127
`define FPM_EXP_MIN (-128)

`endif

// ==== design/fpm_op_pkg.sv ====
/*
	operation codes of the FPM unit
	the decoded enum uses the same encoding as the raw code
*/
`default_nettype none

package fpm_op_pkg;

	// raw code as the producer sends it
	typedef logic [2:0] op_code_t;

	// decoded operation
	typedef enum logic [2:0] {
		// fixed point
		OP_AD = 3'd0,
		OP_SD = 3'd1,
		OP_MW = 3'd2,
		OP_DW = 3'd3,
		// floating point
		OP_AF = 3'd4,
		OP_SF = 3'd5,
		OP_MF = 3'd6,
		OP_DF = 3'd7
	} fpm_op_e;

endpackage

`default_nettype wire

// ==== design/fpm_exp_pkg.sv ====
/*
	exponent types, all two's complement
	exp_wide_t has two guard bits for overflow detection
*/
`default_nettype none

package fpm_exp_pkg;

	// exponent as carried on ports
	typedef logic signed [7:0] exp_t;

	// adder width, holds any sum or difference of two exp_t
	typedef logic signed [9:0] exp_wide_t;

	// alignment shift, 0 to 40
	typedef logic [5:0] shift_t;

endpackage

`default_nettype wire

// ==== design/fpm_decode.sv ====
/*
	input queue and decoder; op_valid is only legal while the producer holds a credit
	an empty queue is bypassed, so an op can issue in the cycle after op_valid
	issue waits for an internal credit, returned by deq from the result queue
*/
`timescale 1ns/1ps
`default_nettype none
`include "fpm_params.svh"

module fpm_decode
	import fpm_op_pkg::*, fpm_exp_pkg::*;
(
	input  logic     f2strob,
	input  logic     rst_n,
	input  logic     op_valid,
	input  op_code_t op_code,
	input  exp_t     exp_a,
	input  exp_t     exp_b,
	input  logic     deq,
	output logic     in_credit,
	output logic     dec_valid,
	output fpm_op_e  dec_op,
	output exp_t     dec_exp_a,
	output exp_t     dec_exp_b
);

	localparam int DEPTH = `FPM_IN_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CRD_W = $clog2(`FPM_OUT_DEPTH + 1);

	op_code_t q_code [DEPTH];
	exp_t q_exp_a [DEPTH];
	exp_t q_exp_b [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] credits;

	logic q_empty;
	logic avail;
	logic pop;
	logic pop_mem;
	logic push_mem;
	op_code_t head_code;
	exp_t head_exp_a;
	exp_t head_exp_b;

	function automatic fpm_op_e decode_op(op_code_t code);
		fpm_op_e op;
		case (code)
			3'd0: op = OP_AD;
			3'd1: op = OP_SD;
			3'd2: op = OP_MW;
			3'd3: op = OP_DW;
			3'd4: op = OP_AF;
			3'd5: op = OP_SF;
			3'd6: op = OP_MF;
			default: op = OP_DF;
		endcase
		return op;
	endfunction

	function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign q_empty = (count == '0);
	assign avail = !q_empty || op_valid;
	assign pop = avail && (credits != '0);
	assign pop_mem = pop && !q_empty;
	// an op that issues on arrival never enters the memory
	assign push_mem = op_valid && !(pop && q_empty);

	assign head_code = q_empty ? op_code : q_code[rd_ptr];
	assign head_exp_a = q_empty ? exp_a : q_exp_a[rd_ptr];
	assign head_exp_b = q_empty ? exp_b : q_exp_b[rd_ptr];

	always_ff @(posedge f2strob) begin
		if (push_mem) begin
			q_code[wr_ptr] <= op_code;
			q_exp_a[wr_ptr] <= exp_a;
			q_exp_b[wr_ptr] <= exp_b;
		end
	end

	always_ff @(posedge f2strob) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= CRD_W'(`FPM_OUT_DEPTH);
			in_credit <= 1'b0;
			dec_valid <= 1'b0;
		end else begin
			if (push_mem)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop_mem)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count + CNT_W'(push_mem) - CNT_W'(pop_mem);
			// spend on issue, refill on deq
			credits <= credits + CRD_W'(deq) - CRD_W'(pop);
			in_credit <= pop;
			dec_valid <= pop;
		end
	end

	always_ff @(posedge f2strob) begin
		if (pop) begin
			dec_op <= decode_op(head_code);
			dec_exp_a <= head_exp_a;
			dec_exp_b <= head_exp_b;
		end
	end

endmodule

`default_nettype wire

// ==== design/fpm_execute.sv ====
/*
	exponent adder, one register stage, never stalls
	the exponent is the low 8 bits for MF/DF even when fi1 or fi2 is set
*/
`timescale 1ns/1ps
`default_nettype none
`include "fpm_params.svh"

module fpm_execute
	import fpm_op_pkg::*, fpm_exp_pkg::*;
(
	input  logic    f2strob,
	input  logic    rst_n,
	input  logic    dec_valid,
	input  fpm_op_e dec_op,
	input  exp_t    dec_exp_a,
	input  exp_t    dec_exp_b,
	output logic    ex_valid,
	output logic    ex_fixed,
	output exp_t    ex_exp,
	output shift_t  ex_shift,
	output logic    ex_g,
	output logic    ex_wdt,
	output logic    ex_fi1,
	output logic    ex_fi2
);

	exp_wide_t a_w;
	exp_wide_t b_w;
	exp_wide_t sum_w;
	exp_wide_t diff_w;
	exp_wide_t mag_w;
	exp_wide_t rng_w;

	logic fixed_n;
	exp_t exp_n;
	shift_t shift_n;
	logic g_n;
	logic wdt_n;
	logic fi1_n;
	logic fi2_n;

	// sign extended operands
	assign a_w = exp_wide_t'(dec_exp_a);
	assign b_w = exp_wide_t'(dec_exp_b);
	assign sum_w = a_w + b_w;
	assign diff_w = a_w - b_w;

	// distance between exponents for alignment
	assign mag_w = diff_w[9] ? -diff_w : diff_w;

	// MF uses the sum, DF the difference
	assign rng_w = (dec_op == OP_MF) ? sum_w : diff_w;

	always_comb begin
		fixed_n = 1'b0;
		exp_n = '0;
		shift_n = '0;
		g_n = 1'b0;
		wdt_n = 1'b0;
		fi1_n = 1'b0;
		fi2_n = 1'b0;
		case (dec_op)
			OP_AF, OP_SF: begin
				// negative difference means operand a is shifted
				wdt_n = diff_w[9];
				g_n = (mag_w >= `FPM_ALIGN_LIMIT);
				shift_n = g_n ? shift_t'(`FPM_ALIGN_LIMIT) : shift_t'(mag_w);
				exp_n = diff_w[9] ? dec_exp_b : dec_exp_a;
			end
			OP_MF, OP_DF: begin
				exp_n = exp_t'(rng_w);
				fi1_n = (rng_w > `FPM_EXP_MAX);
				fi2_n = (rng_w < `FPM_EXP_MIN);
			end
			default: fixed_n = 1'b1;
		endcase
	end

	always_ff @(posedge f2strob) begin
		if (!rst_n)
			ex_valid <= 1'b0;
		else
			ex_valid <= dec_valid;
	end

	always_ff @(posedge f2strob) begin
		if (dec_valid) begin
			ex_fixed <= fixed_n;
			ex_exp <= exp_n;
			ex_shift <= shift_n;
			ex_g <= g_n;
			ex_wdt <= wdt_n;
			ex_fi1 <= fi1_n;
			ex_fi2 <= fi2_n;
		end
	end

endmodule

`default_nettype wire

// ==== design/fpm_result.sv ====
/*
	result queue and output credits; ex_valid must never find the queue full,
	which holds while decode counts deq against FPM_OUT_DEPTH credits
	an empty queue is bypassed so res_valid can follow ex_valid by one cycle
*/
`timescale 1ns/1ps
`default_nettype none
`include "fpm_params.svh"

module fpm_result (
	input  logic       f2strob,
	input  logic       rst_n,
	input  logic       ex_valid,
	input  logic       ex_fixed,
	input  logic [7:0] ex_exp,
	input  logic [5:0] ex_shift,
	input  logic       ex_g,
	input  logic       ex_wdt,
	input  logic       ex_fi1,
	input  logic       ex_fi2,
	input  logic       res_credit,
	output logic       deq,
	output logic       res_valid,
	output logic       res_fixed,
	output logic [7:0] res_exp,
	output logic [5:0] res_shift,
	output logic       res_g,
	output logic       res_wdt,
	output logic       res_fi1,
	output logic       res_fi2
);

	localparam int DEPTH = `FPM_OUT_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CRD_W = $clog2(`FPM_OUT_CREDITS + 1);
	// fixed, exp, shift, g, wdt, fi1, fi2
	localparam int REC_W = 19;

	logic [REC_W-1:0] q_rec [DEPTH];
	logic [REC_W-1:0] rec_in;
	logic [REC_W-1:0] head_rec;
	logic [REC_W-1:0] res_rec;

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] credits;

	logic q_empty;
	logic send;
	logic pop_mem;
	logic push_mem;

	function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign rec_in = {ex_fixed, ex_exp, ex_shift, ex_g, ex_wdt, ex_fi1, ex_fi2};

	assign q_empty = (count == '0);
	assign send = (!q_empty || ex_valid) && (credits != '0);
	assign pop_mem = send && !q_empty;
	assign push_mem = ex_valid && !(send && q_empty);
	assign head_rec = q_empty ? rec_in : q_rec[rd_ptr];

	always_ff @(posedge f2strob) begin
		if (push_mem)
			q_rec[wr_ptr] <= rec_in;
	end

	always_ff @(posedge f2strob) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= CRD_W'(`FPM_OUT_CREDITS);
			res_valid <= 1'b0;
		end else begin
			if (push_mem)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop_mem)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count + CNT_W'(push_mem) - CNT_W'(pop_mem);
			// a returned slot and a send in one cycle cancel out
			credits <= credits + CRD_W'(res_credit) - CRD_W'(send);
			res_valid <= send;
		end
	end

	always_ff @(posedge f2strob) begin
		if (send)
			res_rec <= head_rec;
	end

	assign {res_fixed, res_exp, res_shift, res_g, res_wdt, res_fi1, res_fi2} = res_rec;

	// each record sent frees one slot for decode
	assign deq = res_valid;

endmodule

`default_nettype wire

// ==== design/fpm_unit.sv ====
/*
	exponent and control part of the FPM unit, no mantissa path
	credit flow on both sides; producer starts with FPM_IN_DEPTH credits
*/
`timescale 1ns/1ps
`default_nettype none

module fpm_unit
	import fpm_op_pkg::*, fpm_exp_pkg::*;
(
	input  logic     f2strob,
	input  logic     rst_n,
	input  logic     op_valid,
	input  op_code_t op_code,
	input  exp_t     exp_a,
	input  exp_t     exp_b,
	output logic     in_credit,
	input  logic     res_credit,
	output logic     res_valid,
	output logic     res_fixed,
	output exp_t     res_exp,
	output shift_t   res_shift,
	output logic     res_g,
	output logic     res_wdt,
	output logic     res_fi1,
	output logic     res_fi2
);

	// decode to execute
	logic dec_valid;
	fpm_op_e dec_op;
	exp_t dec_exp_a;
	exp_t dec_exp_b;

	// execute to result
	logic ex_valid;
	logic ex_fixed;
	exp_t ex_exp;
	shift_t ex_shift;
	logic ex_g;
	logic ex_wdt;
	logic ex_fi1;
	logic ex_fi2;

	// internal credit return
	logic deq;

	fpm_decode decode_i (
		.f2strob   (f2strob),
		.rst_n     (rst_n),
		.op_valid  (op_valid),
		.op_code   (op_code),
		.exp_a     (exp_a),
		.exp_b     (exp_b),
		.deq       (deq),
		.in_credit (in_credit),
		.dec_valid (dec_valid),
		.dec_op    (dec_op),
		.dec_exp_a (dec_exp_a),
		.dec_exp_b (dec_exp_b)
	);

	fpm_execute execute_i (
		.f2strob   (f2strob),
		.rst_n     (rst_n),
		.dec_valid (dec_valid),
		.dec_op    (dec_op),
		.dec_exp_a (dec_exp_a),
		.dec_exp_b (dec_exp_b),
		.ex_valid  (ex_valid),
		.ex_fixed  (ex_fixed),
		.ex_exp    (ex_exp),
		.ex_shift  (ex_shift),
		.ex_g      (ex_g),
		.ex_wdt    (ex_wdt),
		.ex_fi1    (ex_fi1),
		.ex_fi2    (ex_fi2)
	);

	fpm_result result_i (
		.f2strob    (f2strob),
		.rst_n      (rst_n),
		.ex_valid   (ex_valid),
		.ex_fixed   (ex_fixed),
		.ex_exp     (ex_exp),
		.ex_shift   (ex_shift),
		.ex_g       (ex_g),
		.ex_wdt     (ex_wdt),
		.ex_fi1     (ex_fi1),
		.ex_fi2     (ex_fi2),
		.res_credit (res_credit),
		.deq        (deq),
		.res_valid  (res_valid),
		.res_fixed  (res_fixed),
		.res_exp    (res_exp),
		.res_shift  (res_shift),
		.res_g      (res_g),
		.res_wdt    (res_wdt),
		.res_fi1    (res_fi1),
		.res_fi2    (res_fi2)
	);

endmodule

`default_nettype wire

// ==== testbench/fpm_unit_properties.sv ====
/*
	concurrent checks on the credit protocol of fpm_unit, bound into every instance
	credit balances are rebuilt from the port pulses, no internal counter is probed
*/
`timescale 1ns/1ps
`default_nettype none
`include "fpm_params.svh"

module fpm_unit_properties (
	input logic f2strob,
	input logic rst_n,
	input logic op_valid,
	input logic in_credit,
	input logic dec_valid,
	input logic ex_valid,
	input logic res_credit,
	input logic res_valid
);

	int out_bal;
	int in_bal;
	logic res_credit_q;

	// balances as seen from the producer and from the consumer
	always_ff @(posedge f2strob) begin
		if (!rst_n) begin
			out_bal <= `FPM_OUT_CREDITS;
			in_bal <= `FPM_IN_DEPTH;
			res_credit_q <= 1'b0;
		end else begin
			out_bal <= out_bal + int'(res_credit) - int'(res_valid);
			in_bal <= in_bal + int'(in_credit) - int'(op_valid);
			res_credit_q <= res_credit;
		end
	end

	// res_valid reflects a send one cycle earlier, when the unit held out_bal - res_credit_q
	res_valid_has_credit: assert property (@(posedge f2strob) disable iff (!rst_n)
		res_valid |-> (out_bal - int'(res_credit_q)) > 0)
		else $error("res_valid without an output credit");

	op_valid_not_full: assert property (@(posedge f2strob) disable iff (!rst_n)
		op_valid |-> in_bal > 0)
		else $error("op_valid while the input queue is full");

	quiet_after_reset: assert property (@(posedge f2strob)
		$rose(rst_n) |-> !in_credit && !dec_valid && !ex_valid && !res_valid)
		else $error("handshake signal high right after reset");

endmodule

bind fpm_unit fpm_unit_properties props_i (
	.f2strob    (f2strob),
	.rst_n      (rst_n),
	.op_valid   (op_valid),
	.in_credit  (in_credit),
	.dec_valid  (dec_valid),
	.ex_valid   (ex_valid),
	.res_credit (res_credit),
	.res_valid  (res_valid)
);

`default_nettype wire

// ==== testbench/fpm_unit_tb.sv ====
/*
	self-checking testbench for fpm_unit
	the consumer withholds credits for HOLD_CYCLES, then frees slots at LFSR gaps
	the hold check assumes the table has more than FPM_IN_DEPTH + FPM_OUT_DEPTH + 2 rows
*/
`timescale 1ns/1ps
`default_nettype none
`include "fpm_params.svh"

module fpm_unit_tb
	import fpm_op_pkg::*;
();

	localparam int HOLD_CYCLES = 40;
	localparam int WAIT_LIMIT = 200;
	localparam int DRAIN_CYCLES = 8;

	logic f2strob;
	logic rst_n;
	logic op_valid;
	logic [2:0] op_code;
	logic [7:0] exp_a;
	logic [7:0] exp_b;
	logic in_credit;
	logic res_credit;
	logic res_valid;
	logic res_fixed;
	logic [7:0] res_exp;
	logic [5:0] res_shift;
	logic res_g;
	logic res_wdt;
	logic res_fi1;
	logic res_fi2;

	// stimulus rows and the records they must produce
	logic [2:0] st_code [$];
	int st_a [$];
	int st_b [$];
	logic [18:0] exp_rec [$];

	int returned;
	int received;
	logic [31:0] lfsr;

	fpm_unit dut_i (
		.f2strob    (f2strob),
		.rst_n      (rst_n),
		.op_valid   (op_valid),
		.op_code    (op_code),
		.exp_a      (exp_a),
		.exp_b      (exp_b),
		.in_credit  (in_credit),
		.res_credit (res_credit),
		.res_valid  (res_valid),
		.res_fixed  (res_fixed),
		.res_exp    (res_exp),
		.res_shift  (res_shift),
		.res_g      (res_g),
		.res_wdt    (res_wdt),
		.res_fi1    (res_fi1),
		.res_fi2    (res_fi2)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// record as {fixed, exp, shift, g, wdt, fi1, fi2}
	function automatic logic [18:0] expected_record(input logic [2:0] code, input int a,
		input int b);
		int r;
		int mag;
		logic [7:0] e;
		logic [5:0] sh;
		logic g;
		logic wdt;
		logic fi1;
		logic fi2;
		if (code < OP_AF)
			return {1'b1, 18'd0};
		e = '0;
		sh = '0;
		g = 1'b0;
		wdt = 1'b0;
		fi1 = 1'b0;
		fi2 = 1'b0;
		if (code == OP_AF || code == OP_SF) begin
			r = a - b;
			wdt = (r < 0);
			mag = (r < 0) ? -r : r;
			g = (mag >= `FPM_ALIGN_LIMIT);
			sh = g ? 6'(`FPM_ALIGN_LIMIT) : 6'(mag);
			e = (a >= b) ? 8'(a) : 8'(b);
		end else begin
			r = (code == OP_MF) ? a + b : a - b;
			e = 8'(r);
			fi1 = (r > `FPM_EXP_MAX);
			fi2 = (r < `FPM_EXP_MIN);
		end
		return {1'b0, e, sh, g, wdt, fi1, fi2};
	endfunction

	task automatic add_row(input fpm_op_e op, input int a, input int b);
		st_code.push_back(op);
		st_a.push_back(a);
		st_b.push_back(b);
		exp_rec.push_back(expected_record(op, a, b));
	endtask

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("mismatch %s: got %0h, expected %0h", name, actual, expected);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic check_record(input logic [18:0] want);
		check_value("res_fixed", res_fixed, want[18]);
		check_value("res_exp", res_exp, want[17:10]);
		check_value("res_shift", res_shift, want[9:4]);
		check_value("res_g", res_g, want[3]);
		check_value("res_wdt", res_wdt, want[2]);
		check_value("res_fi1", res_fi1, want[1]);
		check_value("res_fi2", res_fi2, want[0]);
	endtask

	task automatic run_producer();
		int credits;
		int idle;
		int i;
		credits = `FPM_IN_DEPTH;
		idle = 0;
		i = 0;
		while (i < st_code.size()) begin
			@(posedge f2strob);
			if (in_credit) begin
				credits++;
				returned++;
			end
			if (credits > 0) begin
				op_valid <= 1'b1;
				op_code <= st_code[i];
				exp_a <= 8'(st_a[i]);
				exp_b <= 8'(st_b[i]);
				credits--;
				i++;
				idle = 0;
			end else begin
				op_valid <= 1'b0;
				idle++;
				if (idle > WAIT_LIMIT)
					fail_run("no input credit came back from the unit");
			end
		end
		@(posedge f2strob);
		op_valid <= 1'b0;
	endtask

	task automatic run_consumer();
		int held;
		int idle;
		int cyc;
		logic grant;
		held = 0;
		idle = 0;
		cyc = 0;
		while (received < exp_rec.size()) begin
			@(posedge f2strob);
			cyc++;
			idle++;
			if (res_valid) begin
				if (held == `FPM_OUT_CREDITS)
					fail_run("record arrived with no free consumer slot");
				check_record(exp_rec[received]);
				received++;
				held++;
				idle = 0;
			end
			grant = 1'b0;
			if (cyc > HOLD_CYCLES && held > 0) begin
				lfsr = lfsr_next(lfsr);
				grant = lfsr[0];
			end
			res_credit <= grant;
			if (grant)
				held--;
			if (idle > WAIT_LIMIT)
				fail_run("no result record arrived in time");
			if (cyc == HOLD_CYCLES) begin
				// pipeline stalled with output credits spent and every queue full
				@(negedge f2strob);
				check_value("received", received, `FPM_OUT_CREDITS);
				check_value("in_credit count", returned, `FPM_OUT_DEPTH + `FPM_OUT_CREDITS);
			end
		end
		// any further record is one too many
		repeat (DRAIN_CYCLES) begin
			@(posedge f2strob);
			res_credit <= 1'b0;
			if (res_valid)
				received++;
		end
	endtask

	initial begin
		f2strob = 1'b0;
		forever #50 f2strob = ~f2strob;
	end

	initial begin
		rst_n = 1'b0;
		op_valid = 1'b0;
		op_code = '0;
		exp_a = '0;
		exp_b = '0;
		res_credit = 1'b0;
		returned = 0;
		received = 0;
		lfsr = 32'h3282_f2bd;

		// alignment
		add_row(OP_AF, 10, 3);
		add_row(OP_AF, 3, 10);
		add_row(OP_SF, 5, 5);
		add_row(OP_SF, -20, -12);
		add_row(OP_AF, -4, 30);
		// saturation
		add_row(OP_AF, 40, 0);
		add_row(OP_AF, 20, -20);
		add_row(OP_SF, 0, 41);
		add_row(OP_AF, 127, -128);
		add_row(OP_SF, -128, 127);
		// exponent range
		add_row(OP_MF, 50, 60);
		add_row(OP_MF, 100, 100);
		add_row(OP_MF, -100, -50);
		add_row(OP_MF, 127, 127);
		add_row(OP_DF, 30, 20);
		add_row(OP_DF, 100, -50);
		add_row(OP_DF, -100, 60);
		add_row(OP_DF, -128, 127);
		// fixed point
		add_row(OP_AD, 5, 6);
		add_row(OP_SD, -1, 2);
		add_row(OP_MW, 127, -128);
		add_row(OP_DW, 0, 0);
		add_row(OP_AF, 1, 0);
		add_row(OP_MF, -1, -1);

		repeat (7) begin
			@(posedge f2strob);
			@(negedge f2strob);
			check_value("in_credit", in_credit, 0);
			check_value("res_valid", res_valid, 0);
		end
		@(posedge f2strob);
		rst_n <= 1'b1;
		@(negedge f2strob);
		check_value("in_credit", in_credit, 0);
		check_value("res_valid", res_valid, 0);

		fork
			run_producer();
			run_consumer();
		join

		if (received == exp_rec.size()) begin
			$display("test passed");
			$finish;
		end else begin
			$display("%0d records arrived, %0d expected", received, exp_rec.size());
			$display("test failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// ==== fpm_unit.f ====
+incdir+design
design/fpm_op_pkg.sv
design/fpm_exp_pkg.sv
design/fpm_decode.sv
design/fpm_execute.sv
design/fpm_result.sv
design/fpm_unit.sv
testbench/fpm_unit_properties.sv
testbench/fpm_unit_tb.sv
